// ==== verilog/ps2_pkg.sv ====
// PS/2 host controller constants
// Frame size, protocol timing at a 50 MHz clock and the size of the
// receive FIFO, shared by the receive and command paths
package ps2_pkg;

	// Device frame: start, 8 data, parity, stop
	localparam int frame_bits = 11;

	// Host holds the clock low this long to request sending, 101 us
	localparam int cycles_101us = 5050;

	// Wait for the device to start clocking after release, 15 ms
	localparam int cycles_15ms = 750000;

	// First device edge to acknowledge, 2 ms
	// Also the receive limit for a frame that stops mid-way
	localparam int cycles_2ms = 100000;

	// Wide enough for the 15 ms count
	localparam int timer_width = 20;

	// Receive buffer
	localparam int fifo_depth = 256;
	localparam int fifo_addr_width = 8;

endpackage

// ==== verilog/ps2_rx.sv ====
`timescale 1ns/100ps
// PS/2 receive path
// Synchronizes the clock and data lines, finds falling clock edges and
// shifts in 11-bit device frames, LSB first. A frame with a low start
// bit, odd parity and a high stop bit is passed on as one byte with a
// single-cycle enable. Line activity is ignored while a host command
// owns the bus, and a frame that stalls for 2 ms is dropped.
module ps2_rx (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       ps2_clk_in,
	input  logic       ps2_dat_in,
	input  logic       tx_busy,
	output logic       ps2_clk_fall,
	output logic       ps2_dat_sync,
	output logic [7:0] rx_byte,
	output logic       rx_byte_en
);
	import ps2_pkg::*;

	// Two-flop synchronizers, plus one delay flop for the edge detector
	logic [1:0] clk_sync;
	logic [1:0] dat_sync;
	logic       clk_prev;

	// Frame shift register, start bit ends up in bit 0
	logic [frame_bits-1:0] frame_sr;
	logic [frame_bits-1:0] frame_next;
	// Bits taken so far in this frame, 0 when idle
	logic [3:0]            bit_cnt;
	logic                  last_bit;
	logic                  frame_ok;
	logic                  rx_step;

	// Time since the last edge inside a frame
	logic [timer_width-1:0] stall_timer;
	logic                   stall_done;

	// Lines idle high, so the flops come out of reset high
	// Avoids a false falling edge right after reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			clk_sync <= 2'b11;
			dat_sync <= 2'b11;
			clk_prev <= 1'b1;
		end else begin
			clk_sync <= {clk_sync[0], ps2_clk_in};
			dat_sync <= {dat_sync[0], ps2_dat_in};
			clk_prev <= clk_sync[1];
		end
	end

	assign ps2_clk_fall = clk_prev & ~clk_sync[1];
	assign ps2_dat_sync = dat_sync[1];

	// Only device frames count, not the clocking of a host command
	assign rx_step = ps2_clk_fall & ~tx_busy;

	// Frame as it will look after this edge
	assign frame_next = {ps2_dat_sync, frame_sr[frame_bits-1:1]};
	assign last_bit   = (bit_cnt == 4'(frame_bits - 1));

	// Start low, odd parity over data and parity, stop high
	assign frame_ok = ~frame_next[0] & (^frame_next[frame_bits-2:1]) &
		frame_next[frame_bits-1];

	assign stall_done = (stall_timer == timer_width'(cycles_2ms - 1));

	// Shift register and byte
	always_ff @(posedge clk) begin
		if (rx_step) begin
			frame_sr <= frame_next;
			if (last_bit) begin
				rx_byte <= frame_next[8:1];
			end
		end
	end

	// Bit count, stall timer and byte strobe
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bit_cnt     <= '0;
			stall_timer <= '0;
			rx_byte_en  <= 1'b0;
		end else begin
			rx_byte_en <= 1'b0;
			if (tx_busy) begin
				// Host owns the bus, drop any partial frame
				bit_cnt     <= '0;
				stall_timer <= '0;
			end else if (rx_step) begin
				stall_timer <= '0;
				if (last_bit) begin
					bit_cnt    <= '0;
					// Bad frames just vanish
					rx_byte_en <= frame_ok;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else if (bit_cnt != '0) begin
				if (stall_done) begin
					// Device gave up mid-frame
					bit_cnt     <= '0;
					stall_timer <= '0;
				end else begin
					stall_timer <= stall_timer + 1'b1;
				end
			end
		end
	end

endmodule

// ==== verilog/ps2_tx.sv ====
`timescale 1ns/100ps
// PS/2 command sequencer
// Sends one host byte to the device with the request-to-send sequence:
// clock held low for 101 us, start bit, then data LSB first, odd parity
// and a released stop bit, one per device falling edge. Ends with a
// command_ready pulse on the acknowledge, or a command_timeout pulse if
// the device does not start within 15 ms or finish within 2 ms.
module ps2_tx (
	input  logic       clk,
	input  logic       arst_n,
	input  logic [7:0] command,
	input  logic       command_valid,
	input  logic       ps2_clk_fall,
	input  logic       ps2_dat_sync,
	output logic       ps2_clk_oe,
	output logic       ps2_dat_oe,
	output logic       tx_busy,
	output logic       command_ready,
	output logic       command_timeout
);
	import ps2_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_inhibit,
		st_start,
		st_wait_first,
		st_shift,
		st_wait_ack
	} state_t;

	state_t state;

	// One timer for the clock hold and both timeouts
	logic [timer_width-1:0] timer;
	logic                   inhibit_done;
	logic                   timed_out;

	// Host frame: stop, parity, data, start; bit 0 is on the line
	logic [frame_bits-1:0] tx_frame;
	// Index of the bit now on the data line
	logic [3:0]            bit_cnt;
	logic                  bit_step;

	assign tx_busy = (state != st_idle);

	// Data goes low one cycle before the clock is released
	// Start state is that cycle, so the clock hold is exact
	assign inhibit_done = (timer == timer_width'(cycles_101us - 2));

	always_comb begin
		case (state)
			st_wait_first: timed_out = (timer == timer_width'(cycles_15ms - 1));
			st_shift, st_wait_ack: timed_out = (timer == timer_width'(cycles_2ms - 1));
			default: timed_out = 1'b0;
		endcase
	end

	// Device edge that moves to the next bit
	assign bit_step = ps2_clk_fall & ((state == st_wait_first) | (state == st_shift));

	// Frame register, loaded on accept
	always_ff @(posedge clk) begin
		if ((state == st_idle) && command_valid) begin
			tx_frame <= {1'b1, ~^command, command, 1'b0};
		end else if (bit_step) begin
			// Ones shift in behind, the line stays released
			tx_frame <= {1'b1, tx_frame[frame_bits-1:1]};
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state           <= st_idle;
			timer           <= '0;
			bit_cnt         <= '0;
			ps2_clk_oe      <= 1'b0;
			ps2_dat_oe      <= 1'b0;
			command_ready   <= 1'b0;
			command_timeout <= 1'b0;
		end else begin
			command_ready   <= 1'b0;
			command_timeout <= 1'b0;
			if (timed_out) begin
				// Give up, free both lines
				state           <= st_idle;
				ps2_clk_oe      <= 1'b0;
				ps2_dat_oe      <= 1'b0;
				command_timeout <= 1'b1;
			end else begin
				case (state)
					st_idle: begin
						if (command_valid) begin
							state      <= st_inhibit;
							ps2_clk_oe <= 1'b1;
							timer      <= '0;
							bit_cnt    <= '0;
						end
					end
					st_inhibit: begin
						timer <= timer + 1'b1;
						if (inhibit_done) begin
							// Start bit
							ps2_dat_oe <= 1'b1;
							state      <= st_start;
						end
					end
					st_start: begin
						// Hand the clock to the device
						ps2_clk_oe <= 1'b0;
						timer      <= '0;
						state      <= st_wait_first;
					end
					st_wait_first, st_shift: begin
						timer <= timer + 1'b1;
						if (ps2_clk_fall) begin
							ps2_dat_oe <= ~tx_frame[1];
							bit_cnt    <= bit_cnt + 4'd1;
							// 2 ms window runs from the first edge
							if (state == st_wait_first) begin
								timer <= '0;
							end
							// Stop bit now on the line
							if (bit_cnt == 4'(frame_bits - 2)) begin
								state <= st_wait_ack;
							end else begin
								state <= st_shift;
							end
						end
					end
					st_wait_ack: begin
						timer <= timer + 1'b1;
						// Device holds data low across the acknowledge edge
						if (ps2_clk_fall && !ps2_dat_sync) begin
							command_ready <= 1'b1;
							state         <= st_idle;
						end
					end
					default: begin
						state <= st_idle;
					end
				endcase
			end
		end
	end

endmodule

// ==== verilog/ps2_fifo.sv ====
`timescale 1ns/100ps
// Receive byte FIFO
// Show-ahead: rd_data always shows the oldest byte. A write while full
// is dropped and a read while empty does nothing.
module ps2_fifo (
	input  logic       clk,
	input  logic       arst_n,
	input  logic [7:0] wr_data,
	input  logic       wr_en,
	input  logic       rd_en,
	output logic [7:0] rd_data,
	output logic       empty
);
	import ps2_pkg::*;

	logic [7:0] mem [fifo_depth];

	logic [fifo_addr_width-1:0] wr_ptr;
	logic [fifo_addr_width-1:0] rd_ptr;
	// One bit wider than the pointers to tell full from empty
	logic [fifo_addr_width:0]   count;
	logic                       full;
	logic                       wr_ok;
	logic                       rd_ok;

	assign full  = (count == fifo_depth[fifo_addr_width:0]);
	assign empty = (count == '0);

	// Overflow and underflow guarded here
	assign wr_ok = wr_en & ~full;
	assign rd_ok = rd_en & ~empty;

	// Head straight from the array
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_ok) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_ok, rd_ok})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== verilog/sys_ps2_cntrlr.sv ====
`timescale 1ns/100ps
// PS/2 host controller top
// Receive path into a 256-byte show-ahead FIFO, plus the command path.
// Each open-drain line is split into an input and a pull-low enable,
// the pads live in the chip top.
module sys_ps2_cntrlr (
	input  logic       clk,
	input  logic       arst_n,
	input  logic [7:0] command,
	input  logic       command_valid,
	input  logic       data_ready,
	input  logic       ps2_clk_in,
	input  logic       ps2_dat_in,
	output logic       ps2_clk_oe,
	output logic       ps2_dat_oe,
	output logic       command_ready,
	output logic       command_timeout,
	output logic [7:0] data,
	output logic       data_valid
);

	// Synchronized line state from the receiver
	logic       ps2_clk_fall;
	logic       ps2_dat_sync;
	// Command in flight, receiver stands back
	logic       tx_busy;
	logic [7:0] rx_byte;
	logic       rx_byte_en;
	logic       fifo_empty;

	assign data_valid = ~fifo_empty;

	ps2_rx u_ps2_rx (
		.clk          (clk),
		.arst_n       (arst_n),
		.ps2_clk_in   (ps2_clk_in),
		.ps2_dat_in   (ps2_dat_in),
		.tx_busy      (tx_busy),
		.ps2_clk_fall (ps2_clk_fall),
		.ps2_dat_sync (ps2_dat_sync),
		.rx_byte      (rx_byte),
		.rx_byte_en   (rx_byte_en)
	);

	ps2_tx u_ps2_tx (
		.clk             (clk),
		.arst_n          (arst_n),
		.command         (command),
		.command_valid   (command_valid),
		.ps2_clk_fall    (ps2_clk_fall),
		.ps2_dat_sync    (ps2_dat_sync),
		.ps2_clk_oe      (ps2_clk_oe),
		.ps2_dat_oe      (ps2_dat_oe),
		.tx_busy         (tx_busy),
		.command_ready   (command_ready),
		.command_timeout (command_timeout)
	);

	// Reader pops with data_ready, empty reads ignored inside
	ps2_fifo u_ps2_fifo (
		.clk     (clk),
		.arst_n  (arst_n),
		.wr_data (rx_byte),
		.wr_en   (rx_byte_en),
		.rd_en   (data_ready),
		.rd_data (data),
		.empty   (fifo_empty)
	);

endmodule

// ==== testbench/ps2_tx_checker.sv ====
`timescale 1ns/100ps
// Assertions on the PS/2 command sequencer
// Result pulses are single cycle and never together, and both line
// pulls are off whenever no command is in flight
module ps2_tx_checker (
	input logic clk,
	input logic arst_n,
	input logic tx_busy,
	input logic ps2_clk_oe,
	input logic ps2_dat_oe,
	input logic command_ready,
	input logic command_timeout
);
	// Failure counts, one per property
	int excl_fails;
	int ready_fails;
	int timeout_fails;
	int idle_fails;
	int assert_fails;

	assign assert_fails = excl_fails + ready_fails + timeout_fails + idle_fails;

	// A command ends either acknowledged or timed out
	a_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		!(command_ready && command_timeout))
		else begin
			excl_fails++;
			$error("command_ready and command_timeout high together");
		end

	a_ready_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		command_ready |=> !command_ready)
		else begin
			ready_fails++;
			$error("command_ready longer than one cycle");
		end

	a_timeout_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		command_timeout |=> !command_timeout)
		else begin
			timeout_fails++;
			$error("command_timeout longer than one cycle");
		end

	// Idle host leaves both lines to the device
	a_idle_released: assert property (@(posedge clk) disable iff (!arst_n)
		!tx_busy |-> (!ps2_clk_oe && !ps2_dat_oe))
		else begin
			idle_fails++;
			$error("line pulled low while the sequencer is idle");
		end

endmodule

bind ps2_tx ps2_tx_checker u_ps2_tx_checker (
	.clk             (clk),
	.arst_n          (arst_n),
	.tx_busy         (tx_busy),
	.ps2_clk_oe      (ps2_clk_oe),
	.ps2_dat_oe      (ps2_dat_oe),
	.command_ready   (command_ready),
	.command_timeout (command_timeout)
);

// ==== testbench/tb_ps2.sv ====
`timescale 1ns/100ps
// Testbench for the PS/2 host controller
// Models the device on the split open-drain lines, replays the
// operations in the data file and checks bytes and command results
module tb_ps2;
	import ps2_pkg::*;

	// Device clock half period in system cycles
	localparam int half_period = 20;

	logic       clk = 1'b0;
	logic       arst_n;
	logic [7:0] command;
	logic       command_valid;
	logic       data_ready;
	logic       ps2_clk_oe;
	logic       ps2_dat_oe;
	logic       command_ready;
	logic       command_timeout;
	logic [7:0] data;
	logic       data_valid;

	// Each line is low when either the host or the device pulls it
	logic dev_clk_pull;
	logic dev_dat_pull;
	wire  ps2_clk_line = ~(ps2_clk_oe | dev_clk_pull);
	wire  ps2_dat_line = ~(ps2_dat_oe | dev_dat_pull);

	// Last frame the device took from the host
	logic [10:0] dev_frame;
	int          dev_rx_cnt;
	int          ready_cnt;
	int          timeout_cnt;
	int          watchdog_cycles;

	// Operations from the data file
	string       op_q[$];
	logic [31:0] arg_a_q[$];
	logic [31:0] arg_b_q[$];

	always #2 clk = ~clk;

	sys_ps2_cntrlr u_sys_ps2_cntrlr (
		.clk             (clk),
		.arst_n          (arst_n),
		.command         (command),
		.command_valid   (command_valid),
		.data_ready      (data_ready),
		.ps2_clk_in      (ps2_clk_line),
		.ps2_dat_in      (ps2_dat_line),
		.ps2_clk_oe      (ps2_clk_oe),
		.ps2_dat_oe      (ps2_dat_oe),
		.command_ready   (command_ready),
		.command_timeout (command_timeout),
		.data            (data),
		.data_valid      (data_valid)
	);

	// Count result pulses
	always @(negedge clk) begin
		if (command_ready) ready_cnt <= ready_cnt + 1;
		if (command_timeout) timeout_cnt <= timeout_cnt + 1;
	end

	// Armed once the data file is loaded
	initial begin
		while (watchdog_cycles == 0) @(posedge clk);
		repeat (watchdog_cycles) @(posedge clk);
		fail_run("watchdog expired, the run hung");
	end

	// First failure of a bound assertion ends the run
	always @(negedge clk) begin
		if (u_sys_ps2_cntrlr.u_ps2_tx.u_ps2_tx_checker.assert_fails != 0) begin
			fail_run("assertion failure in the command sequencer checker");
		end
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			fail_run($sformatf("CHECK FAILED %s expected %0h actual %0h", name,
				expected, actual));
		end
	endtask

	// Device frame with start low, LSB first and odd parity unless corrupted
	task automatic send_frame(input logic [7:0] value, input logic bad_parity);
		logic [10:0] bits;
		bits = {1'b1, ~^value ^ bad_parity, value, 1'b0};
		for (int i = 0; i < frame_bits; i++) begin
			dev_dat_pull <= ~bits[i];
			repeat (half_period) @(posedge clk);
			dev_clk_pull <= 1'b1;
			repeat (half_period) @(posedge clk);
			dev_clk_pull <= 1'b0;
		end
		repeat (half_period) @(posedge clk);
	endtask

	// Answers a request to send and acknowledges the frame
	task automatic device_receive();
		logic [10:0] bits;
		int          n;
		n = 0;
		while (!ps2_clk_oe) begin
			@(posedge clk);
			n++;
			if (n > 100) fail_run("device model saw no clock inhibit");
		end
		n = 0;
		while (ps2_clk_oe || !ps2_dat_oe) begin
			@(posedge clk);
			n++;
			if (n > 2 * cycles_101us) fail_run("host never released clock with data low");
		end
		repeat (half_period) @(posedge clk);
		for (int i = 0; i < frame_bits; i++) begin
			// Sample as the clock goes low
			bits[i] = ps2_dat_line;
			dev_clk_pull <= 1'b1;
			repeat (half_period) @(posedge clk);
			dev_clk_pull <= 1'b0;
			repeat (half_period) @(posedge clk);
		end
		// Acknowledge holds data low across one more falling edge
		dev_dat_pull <= 1'b1;
		repeat (half_period) @(posedge clk);
		dev_clk_pull <= 1'b1;
		repeat (half_period) @(posedge clk);
		dev_clk_pull <= 1'b0;
		repeat (half_period) @(posedge clk);
		dev_dat_pull <= 1'b0;
		dev_frame = bits;
		dev_rx_cnt++;
	endtask

	// Wait for the head byte, check it, pop it after a random pause
	task automatic read_byte(input string op, input logic [7:0] expected);
		int n;
		n = 0;
		@(negedge clk);
		while (!data_valid) begin
			n++;
			if (n > 200) fail_run("timed out waiting for data_valid");
			@(negedge clk);
		end
		check({op, " data"}, 32'(expected), 32'(data));
		repeat ($urandom_range(3, 0)) @(posedge clk);
		@(posedge clk);
		data_ready <= 1'b1;
		@(posedge clk);
		data_ready <= 1'b0;
	endtask

	task automatic host_command(input string op, input logic [7:0] value,
		input logic respond);
		int r0;
		int t0;
		int b0;
		int n;
		r0 = ready_cnt;
		t0 = timeout_cnt;
		b0 = dev_rx_cnt;
		command       <= value;
		command_valid <= 1'b1;
		@(posedge clk);
		command_valid <= 1'b0;
		fork
			if (respond) device_receive();
			begin
				// Second request while busy is to be ignored
				repeat (100) @(posedge clk);
				command       <= ~value;
				command_valid <= 1'b1;
				@(posedge clk);
				command_valid <= 1'b0;
			end
		join
		n = 0;
		while (ready_cnt == r0 && timeout_cnt == t0) begin
			@(negedge clk);
			n++;
			if (n > cycles_15ms + cycles_101us + 2000) fail_run("command never finished");
		end
		repeat (200) @(negedge clk);
		check({op, " ready"}, respond ? 1 : 0, ready_cnt - r0);
		check({op, " timeout"}, respond ? 0 : 1, timeout_cnt - t0);
		check({op, " clk_oe"}, 0, 32'(ps2_clk_oe));
		check({op, " dat_oe"}, 0, 32'(ps2_dat_oe));
		if (respond) begin
			check({op, " frames"}, 1, dev_rx_cnt - b0);
			check({op, " start"}, 0, 32'(dev_frame[0]));
			check({op, " byte"}, 32'(value), 32'(dev_frame[8:1]));
			check({op, " parity"}, 1, 32'(^dev_frame[9:1]));
			check({op, " stop"}, 1, 32'(dev_frame[10]));
		end
	endtask

	task automatic run_op(input string op, input logic [31:0] a, input logic [31:0] b);
		int kept;
		if (op == "R") begin
			send_frame(a[7:0], 1'b0);
			read_byte(op, a[7:0]);
		end else if (op == "P") begin
			send_frame(a[7:0], 1'b1);
			repeat (50) @(negedge clk);
			check({op, " valid"}, 0, 32'(data_valid));
		end else if (op == "C") begin
			host_command(op, a[7:0], 1'b1);
		end else if (op == "T") begin
			host_command(op, a[7:0], 1'b0);
		end else if (op == "B") begin
			// data_ready stays low through the burst
			for (int i = 0; i < a; i++) send_frame(8'(b + i), 1'b0);
			kept = (a > fifo_depth) ? fifo_depth : a;
			for (int i = 0; i < kept; i++) read_byte(op, 8'(b + i));
			repeat (20) @(negedge clk);
			check({op, " drained"}, 0, 32'(data_valid));
		end else begin
			fail_run({"unknown operation in data file: ", op});
		end
	endtask

	initial begin
		int          fd;
		int          n;
		int          budget;
		int unsigned seed_val;
		string       line;
		string       op;
		logic [31:0] a;
		logic [31:0] b;
		arst_n        = 1'b0;
		command       = 8'h00;
		command_valid = 1'b0;
		data_ready    = 1'b0;
		dev_clk_pull  = 1'b0;
		dev_dat_pull  = 1'b0;
		seed_val      = $urandom(32'h1bce_8ef6);
		budget        = 1000;
		fd = $fopen("testbench/ps2_testdata.txt", "r");
		if (fd == 0) fail_run("cannot open testbench/ps2_testdata.txt");
		while ($fgets(line, fd) != 0) begin
			b = '0;
			n = (line.getc(0) == "#") ? 0 : $sscanf(line, "%s %h %h", op, a, b);
			if (n >= 2) begin
				op_q.push_back(op);
				arg_a_q.push_back(a);
				arg_b_q.push_back(b);
				budget += (op == "T") ? 2 * cycles_15ms : 120000;
			end
		end
		$fclose(fd);
		watchdog_cycles = budget;
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		repeat (5) @(posedge clk);
		foreach (op_q[i]) begin
			run_op(op_q[i], arg_a_q[i], arg_b_q[i]);
			repeat ($urandom_range(40, 5)) @(posedge clk);
		end
		if (u_sys_ps2_cntrlr.u_ps2_tx.u_ps2_tx_checker.assert_fails != 0) begin
			fail_run("assertion failures in the command sequencer checker");
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

// ==== testbench/ps2_testdata.txt ====
# op arg1 [arg2], all values hex
# R/P byte = good/bad-parity device frame, C/T byte = command answered/ignored, B count first
R a5
R 00
R ff
P 3c
R 3c
C ed
R 1c
C f4
P 55
P 00
R 5a
C 00
T 42
R 81
C ff
B 102 10
R 77
C 0f

// ==== compile.f ====
verilog/ps2_pkg.sv
verilog/ps2_rx.sv
verilog/ps2_tx.sv
verilog/ps2_fifo.sv
verilog/sys_ps2_cntrlr.sv
testbench/ps2_tx_checker.sv
testbench/tb_ps2.sv

// ==== Makefile ====
# Verilator build and run for the PS/2 host controller testbench
VERILATOR ?= verilator
TOP       ?= tb_ps2
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= >>> PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN) testbench/ps2_testdata.txt
	./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '^$(PASS_MSG)$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
